// File: Makefile
# Verilator build and run of the cpu testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
hdl/cpuPkg.sv
hdl/programCounter.sv
hdl/pcUnit.sv
hdl/decoder.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/loadStoreUnit.sv
hdl/cpu.sv
bench/cpu_properties.sv
bench/cpuTb.sv

// File: bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    localparam logic [31:0] BASE = 32'h0000_1000; // 256-byte data window
    localparam logic [31:0] HALT = 32'h0000_006f; // JAL x0, 0
    localparam logic [31:0] NOP  = 32'h0000_0013;

    logic        clk = 1'b0;
    logic        i_rst = 1'b1;
    logic [31:0] busReadData;
    logic [31:0] romReadData;
    logic [2:0]  wrLength;
    logic        wrEnable;
    logic [31:0] busAddress;
    logic [31:0] busWrData;
    logic [31:0] romAddress;

    logic [31:0] rom [0:63];
    bit          jumpTarget [0:63]; // ROM slots some jump lands on
    logic [7:0]  dmem [0:255];
    logic [7:0]  initMem [0:255];
    logic [7:0]  mm [0:255];      // Model data memory
    logic [31:0] mr [0:31];       // Model registers
    logic [31:0] rng = 32'hf5a1_ba8b;
    int          nInstr;
    logic [31:0] expFetch[$];
    logic [31:0] actFetch[$];
    logic [66:0] expWr[$];        // {address, data, length}
    logic [66:0] actWr[$];
    bit          capture = 1'b0;
    string       testName = "reset";
    int          testErrors = 0;
    int          errors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    cpu #(.RESET_VECTOR(32'h0000_0000)) UUT (
        .clk                 (clk),
        .i_rst               (i_rst),
        .i_bus_read_data     (busReadData),
        .i_bus_rom_read_data (romReadData),
        .o_bus_write_length  (wrLength),
        .o_bus_wr_enable     (wrEnable),
        .o_bus_address       (busAddress),
        .o_bus_wr_data       (busWrData),
        .o_bus_rom_address   (romAddress)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Outside the window memory reads back a pattern of the full address
    function automatic logic [7:0] fillByte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] dutByte(input logic [31:0] a);
        return (a[31:8] == BASE[31:8]) ? dmem[a[7:0]] : fillByte(a);
    endfunction

    function automatic logic [7:0] modelByte(input logic [31:0] a);
        return (a[31:8] == BASE[31:8]) ? mm[a[7:0]] : fillByte(a);
    endfunction

    assign romReadData = (romAddress < 32'd64) ? rom[romAddress[5:0]] : NOP;

    always_comb begin
        busReadData = {dutByte(busAddress + 32'd3), dutByte(busAddress + 32'd2),
                       dutByte(busAddress + 32'd1), dutByte(busAddress)};
    end

    // Data memory writes and trace capture
    always @(posedge clk) begin
        logic [31:0] a;
        if (i_rst && wrEnable) begin
            $display("Bus write while reset is asserted in %s", testName);
            testErrors++;
        end
        if (wrEnable) begin
            for (int i = 0; i < 4; i++) begin
                a = busAddress + i;
                if (i < wrLength && a[31:8] == BASE[31:8]) dmem[a[7:0]] <= busWrData[8*i +: 8];
            end
            if (capture) actWr.push_back({busAddress, busWrData, wrLength});
        end
        if (capture) actFetch.push_back(romAddress);
    end

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] ins);
        rom[nInstr] = ins;
        nInstr++;
    endtask

    task automatic addAlu(input logic [4:0] rd);
        logic [31:0] r;
        logic [2:0]  f3;
        r = nextRandom();
        f3 = r[2:0];
        case (r[5:4])
            2'd0: emit(encR((r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                            {2'b0, r[10:8]}, {2'b0, r[13:11]}, f3, rd));
            2'd1: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin // Shift amount form
                    emit(encI({1'b0, r[3] && f3 == 3'd5, 5'b0, r[20:16]},
                              {2'b0, r[13:11]}, f3, rd, 7'h13));
                end else begin
                    emit(encI(r[27:16], {2'b0, r[13:11]}, f3, rd, 7'h13));
                end
            end
            2'd2:    emit({r[31:12], rd, 7'h37});
            default: emit({r[31:12], rd, 7'h17});
        endcase
    endtask

    task automatic addMemOp(input bit isStore, input bit zeroSrc);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [7:0]  off;
        r = nextRandom();
        f3 = isStore ? {1'b0, (r[1:0] == 2'd3) ? 2'd2 : r[1:0]} :
             (r[2:0] == 3'd3 || r[2:0] > 3'd5) ? 3'd2 : r[2:0];
        off = r[15:8] & ~((8'd1 << f3[1:0]) - 8'd1); // Aligned offset
        emit({20'h00001, 5'd7, 7'h37});             // x7 = BASE
        if (isStore) emit(encS({4'b0, off}, zeroSrc ? 5'd0 : {2'b0, r[18:16]}, 5'd7, f3));
        else emit(encI({4'b0, off}, 5'd7, f3, {2'b0, r[18:16]}, 7'h03));
    endtask

    task automatic addControl();
        logic [31:0] r;
        logic [2:0]  f3;
        r = nextRandom();
        case (r[1:0])
            2'd0, 2'd1: begin
                f3 = (r[4:2] == 3'd2 || r[4:2] == 3'd3) ? {1'b1, r[3:2]} : r[4:2];
                jumpTarget[nInstr + r[9:8] + 1] = 1'b1;
                emit(encB({8'd0, {1'b0, r[9:8]} + 3'd1, 2'b00}, {2'b0, r[18:16]},
                          {2'b0, r[21:19]}, f3));
            end
            2'd2: begin
                jumpTarget[nInstr + r[9:8] + 1] = 1'b1;
                emit(encJ({16'd0, {1'b0, r[9:8]} + 3'd1, 2'b00}, {2'b0, r[18:16]}));
            end
            default: begin // AUIPC then JALR, odd immediates test LSB clearing
                while (jumpTarget[nInstr + 1]) begin // JALR only entered through its AUIPC
                    emit(NOP);
                end
                jumpTarget[nInstr + r[9:8] + 2] = 1'b1;
                emit({20'h0, {3'b0, r[14:13]} + 5'd1, 7'h17});
                emit(encI({7'd0, {1'b0, r[9:8]} + 3'd2, 1'b0, r[12]},
                          {3'b0, r[14:13]} + 5'd1, 3'd0, {2'b0, r[18:16]}, 7'h67));
            end
        endcase
    endtask

    task automatic genProgram(input int kind);
        logic [31:0] r;
        for (int i = 0; i < 64; i++) begin
            rom[i] = NOP;
            jumpTarget[i] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            r = nextRandom();
            initMem[i] = r[7:0];
            dmem[i] = r[7:0];
        end
        nInstr = 0;
        for (int i = 1; i < 8; i++) begin // Defined values in x1..x7
            r = nextRandom();
            emit({r[31:12], i[4:0], 7'h37});
            emit(encI(r[11:0], i[4:0], 3'd0, i[4:0], 7'h13));
        end
        while (nInstr < 38) begin
            r = nextRandom();
            case ((kind == 5) ? int'(r[1:0]) : kind)
                0: addAlu({2'b0, r[6:4]});
                1: addMemOp(1'b0, 1'b0);
                2: addControl();
                3: addMemOp(1'b1, 1'b0);
                default: begin
                    addAlu(5'd0);
                    addMemOp(1'b1, 1'b1);
                end
            endcase
        end
        emit({20'h00001, 5'd7, 7'h37});
        for (int i = 0; i < 7; i++) emit(encS(12'(4 * i), i[4:0], 5'd7, 3'd2));
        emit(HALT);
    endtask

    function automatic logic [31:0] aluModel(input logic [2:0] f3, input bit alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit takenModel(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Instruction-set model of the whole program
    task automatic runModel();
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] ld;
        logic [31:0] iImm;
        logic [31:0] sImm;
        logic [2:0]  f3;
        logic [2:0]  len;
        bit          wr;
        expFetch.delete();
        expWr.delete();
        for (int i = 0; i < 32; i++) mr[i] = 32'h0;
        for (int i = 0; i < 256; i++) mm[i] = initMem[i];
        pc = 32'h0;
        for (int steps = 0; steps < 500; steps++) begin
            expFetch.push_back(pc >> 2);
            ins = (pc < 32'd256) ? rom[pc[7:2]] : NOP;
            if (ins == HALT) break;
            f3 = ins[14:12];
            a = mr[ins[19:15]];
            b = mr[ins[24:20]];
            iImm = {{20{ins[31]}}, ins[31:20]};
            sImm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            res = 32'h0;
            wr = 1'b1;
            nextPc = pc + 32'd4;
            case (ins[6:0])
                7'h37: res = {ins[31:12], 12'h0};
                7'h17: res = pc + {ins[31:12], 12'h0};
                7'h6f: begin
                    res = pc + 32'd4;
                    nextPc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'h67: begin
                    res = pc + 32'd4;
                    nextPc = (a + iImm) & ~32'd1;
                end
                7'h63: begin
                    wr = 1'b0;
                    if (takenModel(f3, a, b)) begin
                        nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'h03: begin
                    addr = a + iImm;
                    ld = {modelByte(addr + 32'd3), modelByte(addr + 32'd2),
                          modelByte(addr + 32'd1), modelByte(addr)};
                    case (f3)
                        3'd0:    res = {{24{ld[7]}}, ld[7:0]};
                        3'd1:    res = {{16{ld[15]}}, ld[15:0]};
                        3'd4:    res = {24'h0, ld[7:0]};
                        3'd5:    res = {16'h0, ld[15:0]};
                        default: res = ld;
                    endcase
                end
                7'h23: begin
                    wr = 1'b0;
                    addr = a + sImm;
                    len = (f3 == 3'd0) ? 3'd1 : ((f3 == 3'd1) ? 3'd2 : 3'd4);
                    b = (len == 3'd4) ? b : b & ((32'd1 << (8 * len)) - 32'd1);
                    expWr.push_back({addr, b, len});
                    for (int i = 0; i < len; i++) begin
                        if ((addr + i) >> 8 == BASE >> 8) mm[(addr + i) & 32'hff] = b[8*i +: 8];
                    end
                end
                7'h13: res = aluModel(f3, ins[30] && f3 == 3'd5, a, iImm);
                7'h33: res = aluModel(f3, ins[30], a, b);
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) mr[ins[11:7]] = res;
            pc = nextPc;
        end
    endtask

    task automatic runTest(input string name, input int kind, input int resetAt);
        bit halted;
        int stopAt;
        testName = name;
        testErrors = 0;
        i_rst = 1'b1; // Core held while the ROM is rewritten
        genProgram(kind);
        runModel();
        repeat (2) @(negedge clk);
        if (resetAt > 0) begin // Partial run, then reset while a store executes
            stopAt = resetAt;
            while (stopAt < expFetch.size() && rom[expFetch[stopAt][5:0]][6:0] != 7'h23) begin
                stopAt++;
            end
            i_rst = 1'b0;
            repeat (stopAt) @(negedge clk);
            i_rst = 1'b1;
            repeat (2) @(negedge clk);
            for (int i = 0; i < 256; i++) dmem[i] = initMem[i];
        end
        actFetch.delete();
        actWr.delete();
        capture = 1'b1;
        i_rst = 1'b0;
        halted = 1'b0;
        for (int cycles = 0; cycles < 500 && !halted; cycles++) begin
            @(negedge clk);
            if (actFetch.size() >= 2 && actFetch[$] == actFetch[$-1]) halted = 1'b1;
        end
        capture = 1'b0;
        if (!halted) begin
            $display("Timeout: %s did not reach its halt loop within 500 cycles", name);
            testErrors++;
        end else begin
            void'(actFetch.pop_back()); // Halt address seen twice
            if (actFetch.size() != expFetch.size()) begin
                $display("Error %s: fetch count expected %0d actual %0d", name,
                         expFetch.size(), actFetch.size());
                testErrors++;
            end
            for (int i = 0; i < expFetch.size() && i < actFetch.size(); i++) begin
                if (actFetch[i] !== expFetch[i]) begin
                    $display("Error %s: fetch[%0d] expected %h actual %h", name, i,
                             expFetch[i], actFetch[i]);
                    testErrors++;
                end
            end
            if (actWr.size() != expWr.size()) begin
                $display("Error %s: write count expected %0d actual %0d", name,
                         expWr.size(), actWr.size());
                testErrors++;
            end
            for (int i = 0; i < expWr.size() && i < actWr.size(); i++) begin
                if (actWr[i] !== expWr[i]) begin
                    $display("Error %s: write[%0d] expected %h/%h/%0d actual %h/%h/%0d",
                             name, i, expWr[i][66:35], expWr[i][34:3], expWr[i][2:0],
                             actWr[i][66:35], actWr[i][34:3], actWr[i][2:0]);
                    testErrors++;
                end
            end
        end
        testsRun++;
        if (testErrors != 0) testsFailed++;
        errors += testErrors;
        $display("%s: %s, %0d errors", name, (testErrors == 0) ? "ok" : "FAIL", testErrors);
    endtask

    initial begin
        string kinds [0:4];
        kinds = '{"alu_ops", "loads", "control_flow", "store_widths", "x0_writes"};
        for (int k = 0; k < 5; k++) begin
            for (int rep = 0; rep < 3; rep++) runTest($sformatf("%s_%0d", kinds[k], rep), k, 0);
        end
        runTest("reset_mid_run_0", 5, 12);
        runTest("reset_mid_run_1", 5, 25);
        $display("Tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: bench/cpu_properties.sv
`timescale 1ns/1ps

module cpuProperties (
    input logic        clk,
    input logic        i_rst,
    input logic        i_wrEnable,
    input logic [2:0]  i_writeLength,
    input logic [31:0] i_pc
);

    // Only byte, halfword and word writes exist
    writeLengthLegal: assert property (@(posedge clk) disable iff (i_rst)
        i_wrEnable |-> (i_writeLength inside {3'd1, 3'd2, 3'd4}))
        else $error("Bus write with illegal length %0d", i_writeLength);

    noWriteAfterReset: assert property (@(posedge clk) i_rst |=> !i_wrEnable)
        else $error("Bus write in the cycle after reset");

    pcAligned: assert property (@(posedge clk) disable iff (i_rst) i_pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", i_pc);

endmodule

bind cpu cpuProperties cpuPropertiesInst (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_wrEnable    (o_bus_wr_enable),
    .i_writeLength (o_bus_write_length),
    .i_pc          (pc)
);

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  aluOp_e      i_op,
    input  logic [31:0] i_a,
    input  logic [31:0] i_b,
    output logic [31:0] o_result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = i_b[4:0];
    assign lessSigned   = $signed(i_a) < $signed(i_b);
    assign lessUnsigned = i_a < i_b;

    always_comb begin
        case (i_op)
            ALU_ADD:   o_result = i_a + i_b;
            ALU_SUB:   o_result = i_a - i_b;
            ALU_SLL:   o_result = i_a << shamt;
            ALU_SLT:   o_result = {31'b0, lessSigned};
            ALU_SLTU:  o_result = {31'b0, lessUnsigned};
            ALU_XOR:   o_result = i_a ^ i_b;
            ALU_SRL:   o_result = i_a >> shamt;
            ALU_SRA:   o_result = $unsigned($signed(i_a) >>> shamt);
            ALU_OR:    o_result = i_a | i_b;
            ALU_AND:   o_result = i_a & i_b;
            ALU_EQ:    o_result = {31'b0, i_a == i_b}; // Branch condition in bit 0
            ALU_PASSB: o_result = i_b;
            default:   o_result = 32'h0;
        endcase
    end

endmodule

// File: hdl/cpu.sv
`timescale 1ns/1ps

module cpu import cpuPkg::*; #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        i_rst,
    input  logic [31:0] i_bus_read_data,
    input  logic [31:0] i_bus_rom_read_data,
    output logic [2:0]  o_bus_write_length,
    output logic        o_bus_wr_enable,
    output logic [31:0] o_bus_address,
    output logic [31:0] o_bus_wr_data,
    output logic [31:0] o_bus_rom_address
);

    logic [31:0] pc;
    logic [31:0] pcNext;
    logic [31:0] pcPlusFour;
    logic [31:0] instruction;
    ctrl_t       ctrl;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] loadData;
    logic [31:0] wbData;
    busReq_t     busReq;

    assign instruction       = i_bus_rom_read_data; // ROM answers in the same cycle
    assign o_bus_rom_address = pc >> 2;             // Word index

    programCounter #(.RESET_VECTOR(RESET_VECTOR)) programCounterInst (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_pcNext (pcNext),
        .o_pc     (pc)
    );

    pcUnit pcUnitInst (
        .i_pc          (pc),
        .i_instruction (instruction),
        .i_ctrl        (ctrl),
        .i_aluResult   (aluResult),
        .o_pcPlusFour  (pcPlusFour),
        .o_pcNext      (pcNext)
    );

    decoder decoderInst (
        .i_instruction (instruction),
        .o_ctrl        (ctrl),
        .o_imm         (imm),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .o_rd          (rd)
    );

    registerFile registerFileInst (
        .clk        (clk),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (rd),
        .i_wrEnable (ctrl.regWrite),
        .i_wrData   (wbData),
        .o_rs1Data  (rs1Data),
        .o_rs2Data  (rs2Data)
    );

    // Operand selects, PC for AUIPC and immediate for I/S/U forms
    assign aluA = ctrl.aSelPc ? pc : rs1Data;
    assign aluB = ctrl.bSelImm ? imm : rs2Data;

    alu aluInst (
        .i_op     (ctrl.aluOp),
        .i_a      (aluA),
        .i_b      (aluB),
        .o_result (aluResult)
    );

    loadStoreUnit loadStoreUnitInst (
        .i_rst         (i_rst),
        .i_ctrl        (ctrl),
        .i_address     (aluResult),
        .i_storeData   (rs2Data),
        .i_busReadData (i_bus_read_data),
        .o_req         (busReq),
        .o_loadData    (loadData)
    );

    always_comb begin
        case (ctrl.wbSel)
            WB_MEM:          wbData = loadData;
            WB_PC_PLUS_FOUR: wbData = pcPlusFour; // Link register for JAL/JALR
            default:         wbData = aluResult;
        endcase
    end

    assign o_bus_address      = busReq.address;
    assign o_bus_wr_data      = busReq.wrData;
    assign o_bus_write_length = busReq.writeLength;
    assign o_bus_wr_enable    = busReq.wrEnable;

endmodule

// File: hdl/cpuPkg.sv
package cpuPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,  // Also BLT/BGE compare
        ALU_SLTU  = 4'd4,  // Also BLTU/BGEU compare
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_EQ    = 4'd10, // BEQ/BNE compare
        ALU_PASSB = 4'd11  // LUI
    } aluOp_e;

    typedef enum logic [1:0] {
        PCS_PLUS_FOUR     = 2'd0,
        PCS_JAL_TARGET    = 2'd1,
        PCS_BRANCH_TARGET = 2'd2,
        PCS_JALR_TARGET   = 2'd3
    } pcSource_e;

    typedef enum logic [1:0] {
        WB_ALU          = 2'd0,
        WB_MEM          = 2'd1,
        WB_PC_PLUS_FOUR = 2'd2
    } wbSel_e;

    // Encoded as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } memSize_e;

    typedef struct packed {
        aluOp_e     aluOp;
        logic       aSelPc;      // Operand A is the PC
        logic       bSelImm;     // Operand B is the immediate
        logic       regWrite;
        wbSel_e     wbSel;
        logic       memRead;
        logic       memWrite;
        memSize_e   memSize;
        logic       memUnsigned;
        logic       isBranch;
        logic       isJal;
        logic       isJalr;
        logic [2:0] funct3;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] wrData;
        logic [2:0]  writeLength; // Bytes, 1, 2 or 4
        logic        wrEnable;
    } busReq_t;

endpackage

// File: hdl/decoder.sv
`timescale 1ns/1ps

module decoder import cpuPkg::*; (
    input  logic [31:0] i_instruction,
    output ctrl_t       o_ctrl,
    output logic [31:0] o_imm,
    output logic [4:0]  o_rs1,
    output logic [4:0]  o_rs2,
    output logic [4:0]  o_rd
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // ALU op for OP and OPIMM; SUB only exists in the register form
    function automatic aluOp_e arithOp(input logic [2:0] f3, input logic alt,
                                       input logic isReg);
        case (f3)
            3'b000:  return (alt && isReg) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(i_instruction[6:0]);
    assign funct3 = i_instruction[14:12];
    assign o_rd   = i_instruction[11:7];
    assign o_rs1  = i_instruction[19:15];
    assign o_rs2  = i_instruction[24:20];

    assign immI = {{20{i_instruction[31]}}, i_instruction[31:20]};
    assign immS = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
    assign immB = {{20{i_instruction[31]}}, i_instruction[7], i_instruction[30:25],
                   i_instruction[11:8], 1'b0};
    assign immU = {i_instruction[31:12], 12'h000};
    assign immJ = {{12{i_instruction[31]}}, i_instruction[19:12], i_instruction[20],
                   i_instruction[30:21], 1'b0};

    always_comb begin
        // No-op unless an opcode below claims the instruction
        o_ctrl             = '0;
        o_ctrl.aluOp       = ALU_ADD;
        o_ctrl.wbSel       = WB_ALU;
        o_ctrl.memSize     = memSize_e'(funct3[1:0]);
        o_ctrl.memUnsigned = funct3[2];
        o_ctrl.funct3      = funct3;
        o_imm              = 32'h0;
        case (opcode)
            OPC_LUI: begin
                o_ctrl.aluOp    = ALU_PASSB;
                o_ctrl.bSelImm  = 1'b1;
                o_ctrl.regWrite = 1'b1;
                o_imm           = immU;
            end
            OPC_AUIPC: begin
                o_ctrl.aSelPc   = 1'b1;
                o_ctrl.bSelImm  = 1'b1;
                o_ctrl.regWrite = 1'b1;
                o_imm           = immU;
            end
            OPC_JAL: begin
                o_ctrl.isJal    = 1'b1;
                o_ctrl.regWrite = 1'b1;
                o_ctrl.wbSel    = WB_PC_PLUS_FOUR;
                o_imm           = immJ;
            end
            OPC_JALR: begin
                o_ctrl.isJalr   = 1'b1;
                o_ctrl.bSelImm  = 1'b1;
                o_ctrl.regWrite = 1'b1;
                o_ctrl.wbSel    = WB_PC_PLUS_FOUR;
                o_imm           = immI;
            end
            OPC_BRANCH: begin
                o_ctrl.isBranch = 1'b1;
                case (funct3[2:1])
                    2'b10:   o_ctrl.aluOp = ALU_SLT;
                    2'b11:   o_ctrl.aluOp = ALU_SLTU;
                    default: o_ctrl.aluOp = ALU_EQ;
                endcase
                o_imm = immB;
            end
            OPC_LOAD: begin
                o_ctrl.bSelImm  = 1'b1;
                o_ctrl.memRead  = 1'b1;
                o_ctrl.regWrite = 1'b1;
                o_ctrl.wbSel    = WB_MEM;
                o_imm           = immI;
            end
            OPC_STORE: begin
                o_ctrl.bSelImm  = 1'b1;
                o_ctrl.memWrite = 1'b1;
                o_imm           = immS;
            end
            OPC_OPIMM: begin
                o_ctrl.aluOp    = arithOp(funct3, i_instruction[30], 1'b0);
                o_ctrl.bSelImm  = 1'b1;
                o_ctrl.regWrite = 1'b1;
                o_imm           = immI;
            end
            OPC_OP: begin
                o_ctrl.aluOp    = arithOp(funct3, i_instruction[30], 1'b1);
                o_ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit import cpuPkg::*; (
    input  logic        i_rst,
    input  ctrl_t       i_ctrl,
    input  logic [31:0] i_address,
    input  logic [31:0] i_storeData,
    input  logic [31:0] i_busReadData,
    output busReq_t     o_req,
    output logic [31:0] o_loadData
);

    logic [2:0]  writeLength;
    logic [31:0] storeMask;
    logic [31:0] extended;
    logic        signedLoad;

    always_comb begin
        case (i_ctrl.memSize)
            MEM_BYTE: begin
                writeLength = 3'd1;
                storeMask   = 32'h0000_00ff;
            end
            MEM_HALF: begin
                writeLength = 3'd2;
                storeMask   = 32'h0000_ffff;
            end
            default: begin
                writeLength = 3'd4;
                storeMask   = 32'hffff_ffff;
            end
        endcase
    end

    assign o_req.address     = i_address;
    assign o_req.wrData      = i_storeData & storeMask; // Data sits in the low bytes
    assign o_req.writeLength = writeLength;
    assign o_req.wrEnable    = i_ctrl.memWrite & ~i_rst;

    // Bus returns the word starting at the address, so the data is in the low bits
    assign signedLoad = ~i_ctrl.memUnsigned;

    always_comb begin
        case (i_ctrl.memSize)
            MEM_BYTE: extended = {{24{signedLoad & i_busReadData[7]}}, i_busReadData[7:0]};
            MEM_HALF: extended = {{16{signedLoad & i_busReadData[15]}}, i_busReadData[15:0]};
            default:  extended = i_busReadData;
        endcase
    end

    assign o_loadData = i_ctrl.memRead ? extended : 32'h0;

endmodule

// File: hdl/pcUnit.sv
`timescale 1ns/1ps

module pcUnit import cpuPkg::*; (
    input  logic [31:0] i_pc,
    input  logic [31:0] i_instruction,
    input  ctrl_t       i_ctrl,
    input  logic [31:0] i_aluResult,
    output logic [31:0] o_pcPlusFour,
    output logic [31:0] o_pcNext
);

    logic [31:0] jalOffset;
    logic [31:0] branchOffset;
    logic [31:0] jalTarget;
    logic [31:0] branchTarget;
    logic [31:0] jalrTarget;
    logic        branchTaken;
    pcSource_e   pcSource;

    // J and B immediates taken straight from the instruction word
    assign jalOffset = {{12{i_instruction[31]}}, i_instruction[19:12],
                        i_instruction[20], i_instruction[30:21], 1'b0};
    assign branchOffset = {{20{i_instruction[31]}}, i_instruction[7],
                           i_instruction[30:25], i_instruction[11:8], 1'b0};

    assign o_pcPlusFour = i_pc + 32'd4;
    assign jalTarget    = i_pc + jalOffset;
    assign branchTarget = i_pc + branchOffset;
    assign jalrTarget   = {i_aluResult[31:1], 1'b0}; // rs1 + imm, LSB cleared

    // BEQ/BLT/BLTU take on a true compare, BNE/BGE/BGEU on a false one.
    // funct3[0] marks the inverted forms.
    assign branchTaken = i_aluResult[0] ^ i_ctrl.funct3[0];

    always_comb begin
        if (i_ctrl.isJal) begin
            pcSource = PCS_JAL_TARGET;
        end else if (i_ctrl.isJalr) begin
            pcSource = PCS_JALR_TARGET;
        end else if (i_ctrl.isBranch && branchTaken) begin
            pcSource = PCS_BRANCH_TARGET;
        end else begin
            pcSource = PCS_PLUS_FOUR;
        end
    end

    always_comb begin
        case (pcSource)
            PCS_JAL_TARGET:    o_pcNext = jalTarget;
            PCS_BRANCH_TARGET: o_pcNext = branchTarget;
            PCS_JALR_TARGET:   o_pcNext = jalrTarget;
            default:           o_pcNext = o_pcPlusFour;
        endcase
    end

endmodule

// File: hdl/programCounter.sv
`timescale 1ns/1ps

module programCounter #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        i_rst,
    input  logic [31:0] i_pcNext,
    output logic [31:0] o_pc
);

    logic [31:0] pcReg;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pcReg <= RESET_VECTOR;
        end else begin
            pcReg <= i_pcNext; // New instruction every cycle
        end
    end

    assign o_pc = pcReg;

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic        clk,
    input  logic [4:0]  i_rs1,
    input  logic [4:0]  i_rs2,
    input  logic [4:0]  i_rd,
    input  logic        i_wrEnable,
    input  logic [31:0] i_wrData,
    output logic [31:0] o_rs1Data,
    output logic [31:0] o_rs2Data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (i_wrEnable && (i_rd != 5'd0)) begin
            regs[i_rd] <= i_wrData;
        end
    end

    // Asynchronous reads
    assign o_rs1Data = (i_rs1 == 5'd0) ? 32'h0 : regs[i_rs1];
    assign o_rs2Data = (i_rs2 == 5'd0) ? 32'h0 : regs[i_rs2];

endmodule
